/* archie_support_top.f */
source/archie_clk_pkg.sv
source/archie_mem_pkg.sv
source/clk_enable_gen.sv
source/pll_reconfig_seq.sv
source/back_porch_blank.sv
source/rom_loader_arb.sv
source/archie_support_top.sv
testbench/tb_archie_support_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the archie_support_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f archie_support_top.f \
	--top-module tb_archie_support_top \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Regression passed" sim.log; then
	exit 0
fi
echo "simulation did not report a pass, see sim.log"
exit 1

/* testbench/tb_archie_support_top.sv */
module tb_archie_support_top import archie_clk_pkg::*, archie_mem_pkg::*; ();

	logic clk_sys, rst_n_i, reconfig_busy_i, pix_ce_i, core_hs_i, core_vs_i;
	pixbase_e pixbase_sel_i;
	logic [COLOR_W-1:0] core_r_i, core_g_i, core_b_i, vid_r_o, vid_g_o, vid_b_o;
	logic clk2m_en_o, clk8m_en_o, rc_write_rom_o, rc_start_o, rc_reset_o, vid_clk_ena_o;
	logic vid_hs_o, vid_vs_o, dl_active_i, loader_we_i, core_stb_i, core_we_i, core_ack_o;
	logic [LOADER_INDEX_W-1:0] dl_index_i;
	logic [LOADER_ADDR_W-1:0] loader_addr_i, core_adr_i;
	logic [7:0] loader_data_i;
	logic [MEM_SEL_W-1:0] core_sel_i, ram_sel_o;
	logic [MEM_DATA_W-1:0] core_wdata_i, ram_wdata_o;
	logic ram_stb_o, ram_cyc_o, ram_we_o, ram_ack_i, ram_ready_i, reset_button_i, core_reset_o;
	logic [RAM_ADDR_W-1:0] ram_adr_o;

	int chk_errors, timeout_errors, gap2, gap8, ack_wait, busy_cnt, since_start, hs_cnt;
	int blank_lo, blank_hi;
	logic seen2, seen8, hold_busy, pending_start, quiet, reset_seen, blank_en;
	logic prev_dl, rom_done, in_rom_dl, reloading;
	logic [LOADER_ADDR_W-1:0] exp_addr;
	logic [7:0] exp_byte;
	logic [11:0] prev_rgb;
	logic [1:0] prev_sync;

	archie_support_top archie_support_top_inst (.*);

	always #50 clk_sys = ~clk_sys;

	assign in_rom_dl = dl_active_i && (dl_index_i >= 8'd1) && (dl_index_i <= 8'd2);

	task automatic report_check(input string msg);
		chk_errors++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic note_timeout(input string what);
		timeout_errors++;
		$display("timeout at %0t: %s did not happen in time", $time, what);
	endtask

	// RAM answers 1 to 4 cycles after it sees a strobe
	always @(posedge clk_sys) begin
		if (!rst_n_i) begin
			ram_ack_i <= 1'b0;
			ack_wait <= 0;
		end else if (ram_ack_i) begin
			ram_ack_i <= 1'b0;
		end else if (ram_stb_o) begin
			if (ack_wait == 0) begin
				ram_ack_i <= 1'b1;
				ack_wait <= int'($urandom % 4);
			end else ack_wait <= ack_wait - 1;
		end
	end

	// reconfig controller, busy for 2 to 20 cycles after each start
	always @(posedge clk_sys) begin
		if (!rst_n_i) begin
			reconfig_busy_i <= 1'b0;
			busy_cnt <= 0;
		end else if (rc_start_o) begin
			reconfig_busy_i <= 1'b1;
			busy_cnt <= 2 + int'($urandom % 19);
		end else if (busy_cnt > 1) begin
			busy_cnt <= busy_cnt - 1;
		end else begin
			busy_cnt <= 0;
			reconfig_busy_i <= hold_busy && reconfig_busy_i; // stuck controller
		end
	end

	// reference state for the checks
	always @(posedge clk_sys) begin
		if (!rst_n_i) begin
			seen2 <= 1'b0;
			seen8 <= 1'b0;
			gap2 <= 0;
			gap8 <= 0;
			pending_start <= 1'b0;
			reloading <= 1'b0;
			reset_seen <= 1'b0;
			since_start <= 0;
			prev_dl <= 1'b0;
			rom_done <= 1'b0;
			hs_cnt <= 0;
		end else begin
			gap2 <= clk2m_en_o ? 0 : gap2 + 1;
			gap8 <= clk8m_en_o ? 0 : gap8 + 1;
			if (clk2m_en_o) seen2 <= 1'b1;
			if (clk8m_en_o) seen8 <= 1'b1;
			if (rc_write_rom_o) pending_start <= 1'b1;
			else if (rc_start_o) pending_start <= 1'b0;
			// reload lasts until the controller is idle again or gets kicked
			if (rc_write_rom_o) reloading <= 1'b1;
			else if (rc_reset_o || (!pending_start && !rc_start_o && !reconfig_busy_i))
				reloading <= 1'b0;
			if (rc_reset_o) reset_seen <= 1'b1;
			since_start <= rc_start_o ? 1 : since_start + 1;
			prev_dl <= in_rom_dl;
			if (prev_dl && !in_rom_dl) rom_done <= 1'b1; // ROM image complete
			hs_cnt <= vid_hs_o ? hs_cnt + 1 : 0;
		end
		prev_rgb <= {core_r_i, core_g_i, core_b_i};
		prev_sync <= {core_hs_i, core_vs_i};
	end

	a_clk2m_gap: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		seen2 |-> (clk2m_en_o ? gap2 == 19 : gap2 < 19)) else report_check("2 MHz enable spacing");
	a_clk8m_gap: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		seen8 |-> (clk8m_en_o ? gap8 == 4 : gap8 < 4)) else report_check("8 MHz enable spacing");
	a_clk_align: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		clk2m_en_o |-> clk8m_en_o) else report_check("2 MHz enable without 8 MHz enable");
	a_loader_write: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(in_rom_dl && ram_stb_o) |-> (ram_we_o && ram_sel_o == (4'b0001 << exp_addr[1:0])
		&& ram_wdata_o == {4{exp_byte}} && ram_adr_o == {2'b00, exp_addr[23:2], 2'b00}))
		else report_check("loader write to RAM");
	a_no_core_ack: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		in_rom_dl |-> !core_ack_o) else report_check("core ack during ROM load");
	a_other_index: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(dl_active_i && !in_rom_dl && !core_stb_i) |-> !ram_stb_o)
		else report_check("RAM strobe from non-ROM download");
	a_bus_stable: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(ram_stb_o && !ram_ack_i) |=> (ram_stb_o && $stable(ram_adr_o) && $stable(ram_sel_o)
		&& $stable(ram_wdata_o) && $stable(ram_we_o))) else report_check("RAM bus not held");
	a_cyc: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		ram_cyc_o == ram_stb_o) else report_check("cyc differs from stb");
	a_pass: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		!in_rom_dl |-> (ram_stb_o == core_stb_i && ram_we_o == core_we_i
		&& ram_sel_o == core_sel_i && ram_wdata_o == core_wdata_i && core_ack_o == ram_ack_i
		&& ram_adr_o == {2'b00, core_adr_i[23:2], 2'b00})) else report_check("core pass-through");
	a_reset_hold: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(!ram_ready_i || !rom_done) |-> core_reset_o) else report_check("core reset released early");
	a_reset_button: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(ram_ready_i && rom_done) |-> core_reset_o == reset_button_i)
		else report_check("core reset does not follow button");
	a_start_idle: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		rc_start_o |-> (!reconfig_busy_i && pending_start)) else report_check("start pulse");
	a_one_write: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		rc_write_rom_o |-> !pending_start) else report_check("second write_rom before start");
	a_sel_change: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(pixbase_sel_i != $past(pixbase_sel_i)) |=> (rc_write_rom_o && !vid_clk_ena_o))
		else report_check("select change not applied");
	a_vid_gate: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		reloading |-> !vid_clk_ena_o) else report_check("video enable during reload");
	a_quiet: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		quiet |-> !(rc_write_rom_o || rc_start_o || rc_reset_o))
		else report_check("pulse on unchanged select");
	a_timeout_reset: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		rc_reset_o |-> (since_start >= 1000 && since_start <= 1010))
		else report_check("reconfig reset at wrong time");
	a_porch_blank: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(blank_en && vid_hs_o && hs_cnt < blank_lo) |-> {vid_r_o, vid_g_o, vid_b_o} == 12'h0)
		else report_check("colour during back porch");
	a_porch_pass: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(blank_en && vid_hs_o && hs_cnt >= blank_hi) |-> {vid_r_o, vid_g_o, vid_b_o} == prev_rgb)
		else report_check("colour after back porch");
	a_sync_pass: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		{vid_hs_o, vid_vs_o} == prev_sync) else report_check("sync not registered through");

	task automatic send_byte(input logic [23:0] addr, input logic [7:0] data);
		int n;
		@(posedge clk_sys);
		loader_we_i <= 1'b1;
		loader_addr_i <= addr;
		loader_data_i <= data;
		exp_addr <= addr;
		exp_byte <= data;
		@(posedge clk_sys);
		loader_we_i <= 1'b0;
		for (n = 0; n < 20; n++) begin
			@(posedge clk_sys);
			if (ram_ack_i) break;
		end
		if (n == 20) note_timeout("RAM ack for loader byte");
	endtask

	task automatic core_write(input logic [23:0] adr, input logic [31:0] data);
		int n;
		@(posedge clk_sys);
		core_stb_i <= 1'b1;
		core_we_i <= 1'b1;
		core_sel_i <= 4'($urandom);
		core_adr_i <= adr;
		core_wdata_i <= data;
		for (n = 0; n < 20; n++) begin
			@(posedge clk_sys);
			if (ram_ack_i) break;
		end
		if (n == 20) note_timeout("RAM ack for core access");
		core_stb_i <= 1'b0;
	endtask

	task automatic apply_sel(input pixbase_e sel);
		int n;
		@(posedge clk_sys);
		pixbase_sel_i <= sel;
		for (n = 0; n < 5; n++) begin
			@(posedge clk_sys);
			if (!vid_clk_ena_o) break;
		end
		if (n == 5) note_timeout("video enable drop");
		for (n = 0; n < 1100; n++) begin
			@(posedge clk_sys);
			if (vid_clk_ena_o) break;
		end
		if (n == 1100) note_timeout("end of PLL reload");
	endtask

	task automatic drive_colour();
		core_r_i <= 4'(1 + $urandom % 15);
		core_g_i <= 4'(1 + $urandom % 15);
		core_b_i <= 4'(1 + $urandom % 15);
	endtask

	task automatic run_porch(input pixbase_e sel, input int lo, input int hi);
		if (sel != pixbase_sel_i) apply_sel(sel);
		@(posedge clk_sys);
		blank_lo <= lo;
		blank_hi <= hi;
		blank_en <= 1'b1;
		core_hs_i <= 1'b0;
		repeat (10) begin
			@(posedge clk_sys);
			drive_colour();
			core_vs_i <= 1'($urandom);
		end
		core_hs_i <= 1'b1;
		repeat (300) begin
			@(posedge clk_sys);
			drive_colour();
			core_vs_i <= 1'($urandom);
		end
		core_hs_i <= 1'b0;
		blank_en <= 1'b0;
	endtask

	initial begin
		clk_sys = 1'b0;
		rst_n_i = 1'b0;
		pixbase_sel_i = PIXBASE_36; // matches the PLL setting after reset
		pix_ce_i = 1'b1;
		{core_r_i, core_g_i, core_b_i, core_hs_i, core_vs_i} = '0;
		{dl_active_i, dl_index_i, loader_we_i, loader_addr_i, loader_data_i} = '0;
		{core_stb_i, core_we_i, core_sel_i, core_adr_i, core_wdata_i} = '0;
		ram_ready_i = 1'b0;
		reset_button_i = 1'b0;
		{hold_busy, quiet, blank_en, exp_addr, exp_byte} = '0;
		blank_lo = 0;
		blank_hi = 0;
		chk_errors = 0;
		timeout_errors = 0;
		void'($urandom(32'h4f84));
		repeat (5) @(posedge clk_sys);
		rst_n_i <= 1'b1;
		repeat (30) @(posedge clk_sys);
		ram_ready_i <= 1'b1;

		// ROM image into RAM
		@(posedge clk_sys);
		dl_index_i <= 8'd1;
		dl_active_i <= 1'b1;
		for (int i = 0; i < 12; i++) send_byte(24'($urandom), 8'($urandom));
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (5) @(posedge clk_sys);
		reset_button_i <= 1'b1;
		repeat (4) @(posedge clk_sys);
		reset_button_i <= 1'b0;

		for (int i = 0; i < 8; i++) core_write(24'($urandom), $urandom);

		// download of a non-ROM file, one byte only
		@(posedge clk_sys);
		dl_index_i <= 8'd5;
		dl_active_i <= 1'b1;
		@(posedge clk_sys);
		loader_we_i <= 1'b1;
		@(posedge clk_sys);
		loader_we_i <= 1'b0;
		repeat (20) @(posedge clk_sys);
		dl_active_i <= 1'b0;

		apply_sel(PIXBASE_25);
		@(posedge clk_sys);
		quiet <= 1'b1;
		pixbase_sel_i <= PIXBASE_25;
		repeat (30) @(posedge clk_sys);
		quiet <= 1'b0;

		// controller that never finishes
		hold_busy <= 1'b1;
		apply_sel(PIXBASE_24A);
		hold_busy <= 1'b0;
		repeat (30) @(posedge clk_sys);
		a_reset_pulse: assert (reset_seen) else report_check("no reconfig reset pulse");

		run_porch(PIXBASE_25, 60, 70);
		run_porch(PIXBASE_36, 60, 70);
		run_porch(PIXBASE_24A, 250, 262);
		run_porch(PIXBASE_24B, 250, 262);
		repeat (20) @(posedge clk_sys);

		$display("check errors: %0d, timeouts: %0d", chk_errors, timeout_errors);
		if (chk_errors == 0 && timeout_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* source/archie_support_top.sv */
module archie_support_top import archie_clk_pkg::*, archie_mem_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      rst_n_i,
	// clock enables
	output logic                      clk2m_en_o,
	output logic                      clk8m_en_o,
	// PLL reconfig controller
	input  pixbase_e                  pixbase_sel_i,
	input  logic                      reconfig_busy_i,
	output logic                      rc_write_rom_o,
	output logic                      rc_start_o,
	output logic                      rc_reset_o,
	output logic                      vid_clk_ena_o,
	// video
	input  logic                      pix_ce_i,
	input  logic [COLOR_W-1:0]        core_r_i,
	input  logic [COLOR_W-1:0]        core_g_i,
	input  logic [COLOR_W-1:0]        core_b_i,
	input  logic                      core_hs_i,
	input  logic                      core_vs_i,
	output logic [COLOR_W-1:0]        vid_r_o,
	output logic [COLOR_W-1:0]        vid_g_o,
	output logic [COLOR_W-1:0]        vid_b_o,
	output logic                      vid_hs_o,
	output logic                      vid_vs_o,
	// host download
	input  logic                      dl_active_i,
	input  logic [LOADER_INDEX_W-1:0] dl_index_i,
	input  logic                      loader_we_i,
	input  logic [LOADER_ADDR_W-1:0]  loader_addr_i,
	input  logic [7:0]                loader_data_i,
	// core wishbone
	input  logic                      core_stb_i,
	input  logic                      core_we_i,
	input  logic [MEM_SEL_W-1:0]      core_sel_i,
	input  logic [LOADER_ADDR_W-1:0]  core_adr_i,
	input  logic [MEM_DATA_W-1:0]     core_wdata_i,
	output logic                      core_ack_o,
	// RAM wishbone
	output logic                      ram_stb_o,
	output logic                      ram_cyc_o,
	output logic                      ram_we_o,
	output logic [MEM_SEL_W-1:0]      ram_sel_o,
	output logic [RAM_ADDR_W-1:0]     ram_adr_o,
	output logic [MEM_DATA_W-1:0]     ram_wdata_o,
	input  logic                      ram_ack_i,
	input  logic                      ram_ready_i,
	input  logic                      reset_button_i,
	output logic                      core_reset_o
);

	rom_loader_arb rom_loader_arb_inst (
		.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i),
		.loader_we_i(loader_we_i), .loader_addr_i(loader_addr_i),
		.loader_data_i(loader_data_i),
		.core_stb_i(core_stb_i), .core_we_i(core_we_i), .core_sel_i(core_sel_i),
		.core_adr_i(core_adr_i), .core_wdata_i(core_wdata_i), .core_ack_o(core_ack_o),
		.ram_stb_o(ram_stb_o), .ram_cyc_o(ram_cyc_o), .ram_we_o(ram_we_o),
		.ram_sel_o(ram_sel_o), .ram_adr_o(ram_adr_o), .ram_wdata_o(ram_wdata_o),
		.ram_ack_i(ram_ack_i), .ram_ready_i(ram_ready_i),
		.reset_button_i(reset_button_i), .core_reset_o(core_reset_o)
	);

	clk_enable_gen clk_enable_gen_inst (
		.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.clk2m_en_o(clk2m_en_o), .clk8m_en_o(clk8m_en_o)
	);

	pll_reconfig_seq pll_reconfig_seq_inst (
		.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.pixbase_sel_i(pixbase_sel_i), .reconfig_busy_i(reconfig_busy_i),
		.rc_write_rom_o(rc_write_rom_o), .rc_start_o(rc_start_o),
		.rc_reset_o(rc_reset_o), .vid_clk_ena_o(vid_clk_ena_o)
	);

	back_porch_blank back_porch_blank_inst (
		.clk_sys(clk_sys), .rst_n_i(rst_n_i),
		.pix_ce_i(pix_ce_i), .pixbase_sel_i(pixbase_sel_i),
		.core_r_i(core_r_i), .core_g_i(core_g_i), .core_b_i(core_b_i),
		.core_hs_i(core_hs_i), .core_vs_i(core_vs_i),
		.vid_r_o(vid_r_o), .vid_g_o(vid_g_o), .vid_b_o(vid_b_o),
		.vid_hs_o(vid_hs_o), .vid_vs_o(vid_vs_o)
	);

endmodule

/* source/rom_loader_arb.sv */
module rom_loader_arb import archie_mem_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      rst_n_i,
	input  logic                      dl_active_i,
	input  logic [LOADER_INDEX_W-1:0] dl_index_i,
	input  logic                      loader_we_i,
	input  logic [LOADER_ADDR_W-1:0]  loader_addr_i,
	input  logic [7:0]                loader_data_i,
	input  logic                      core_stb_i,
	input  logic                      core_we_i,
	input  logic [MEM_SEL_W-1:0]      core_sel_i,
	input  logic [LOADER_ADDR_W-1:0]  core_adr_i,
	input  logic [MEM_DATA_W-1:0]     core_wdata_i,
	output logic                      core_ack_o,
	output logic                      ram_stb_o,
	output logic                      ram_cyc_o,
	output logic                      ram_we_o,
	output logic [MEM_SEL_W-1:0]      ram_sel_o,
	output logic [RAM_ADDR_W-1:0]     ram_adr_o,
	output logic [MEM_DATA_W-1:0]     ram_wdata_o,
	input  logic                      ram_ack_i,
	input  logic                      ram_ready_i,
	input  logic                      reset_button_i,
	output logic                      core_reset_o
);

	logic rom_loading;
	logic rom_loading_q;
	logic rom_ready_q; // set once the first ROM image is in
	logic loader_stb_q;
	logic [LOADER_ADDR_W-1:0] loader_addr_q;
	logic [7:0] loader_data_q;
	logic [MEM_SEL_W-1:0] loader_sel;

	assign rom_loading = dl_active_i &&
		(dl_index_i >= LOADER_INDEX_W'(ROM_INDEX_LO)) &&
		(dl_index_i <= LOADER_INDEX_W'(ROM_INDEX_HI));

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			rom_loading_q <= 1'b0;
			rom_ready_q <= 1'b0;
			loader_stb_q <= 1'b0;
		end else begin
			rom_loading_q <= rom_loading;
			if (rom_loading_q && !rom_loading) rom_ready_q <= 1'b1;
			if (loader_we_i) begin
				loader_stb_q <= 1'b1;
			end else if (ram_ack_i) begin
				loader_stb_q <= 1'b0;
			end
		end
	end

	// byte and address held for the whole strobe
	always_ff @(posedge clk_sys) begin
		if (loader_we_i) begin
			loader_addr_q <= loader_addr_i;
			loader_data_q <= loader_data_i;
		end
	end

	assign loader_sel = MEM_SEL_W'(1) << loader_addr_q[1:0]; // byte lane

	always_comb begin
		if (rom_loading) begin
			ram_stb_o = loader_stb_q;
			ram_we_o = 1'b1;
			ram_sel_o = loader_sel;
			ram_adr_o = {{(RAM_ADDR_W-LOADER_ADDR_W){1'b0}},
				loader_addr_q[LOADER_ADDR_W-1:2], 2'b00};
			ram_wdata_o = {4{loader_data_q}};
			core_ack_o = 1'b0; // core stalls while ROM loads
		end else begin
			ram_stb_o = core_stb_i;
			ram_we_o = core_we_i;
			ram_sel_o = core_sel_i;
			ram_adr_o = {{(RAM_ADDR_W-LOADER_ADDR_W){1'b0}},
				core_adr_i[LOADER_ADDR_W-1:2], 2'b00};
			ram_wdata_o = core_wdata_i;
			core_ack_o = ram_ack_i;
		end
	end

	assign ram_cyc_o = ram_stb_o;

	assign core_reset_o = !ram_ready_i || !rom_ready_q || reset_button_i;

	// host has to wait for the ack before sending the next byte
	a_loader_no_overrun: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		(loader_stb_q && !ram_ack_i) |-> !loader_we_i
	);

endmodule

/* source/back_porch_blank.sv */
module back_porch_blank import archie_clk_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst_n_i,
	input  logic               pix_ce_i,
	input  pixbase_e           pixbase_sel_i,
	input  logic [COLOR_W-1:0] core_r_i,
	input  logic [COLOR_W-1:0] core_g_i,
	input  logic [COLOR_W-1:0] core_b_i,
	input  logic               core_hs_i,
	input  logic               core_vs_i,
	output logic [COLOR_W-1:0] vid_r_o,
	output logic [COLOR_W-1:0] vid_g_o,
	output logic [COLOR_W-1:0] vid_b_o,
	output logic               vid_hs_o,
	output logic               vid_vs_o
);

	logic [$clog2(PORCH_TV_LEN)-1:0] porch_cnt_q;
	logic tv_mode;
	logic porch_done; // counter saturated, porch is over

	assign tv_mode = (pixbase_sel_i[0] == pixbase_sel_i[1]);
	assign porch_done = tv_mode ? &porch_cnt_q : &porch_cnt_q[$clog2(PORCH_VGA_LEN)-1:0];

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			porch_cnt_q <= '0;
			vid_hs_o <= 1'b0;
			vid_vs_o <= 1'b0;
			vid_r_o <= '0;
			vid_g_o <= '0;
			vid_b_o <= '0;
		end else begin
			if (!porch_done) porch_cnt_q <= porch_cnt_q + 1'b1;
			if (!vid_hs_o) porch_cnt_q <= '0; // restart on every sync pulse
			if (pix_ce_i) begin
				vid_hs_o <= core_hs_i;
				vid_vs_o <= core_vs_i;
				if (porch_done) begin
					vid_r_o <= core_r_i;
					vid_g_o <= core_g_i;
					vid_b_o <= core_b_i;
				end else begin
					vid_r_o <= '0;
					vid_g_o <= '0;
					vid_b_o <= '0;
				end
			end
		end
	end

endmodule

/* source/pll_reconfig_seq.sv */
module pll_reconfig_seq import archie_clk_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n_i,
	input  pixbase_e pixbase_sel_i,
	input  logic     reconfig_busy_i,
	output logic     rc_write_rom_o,
	output logic     rc_start_o,
	output logic     rc_reset_o,
	output logic     vid_clk_ena_o
);

	reconfig_state_e state_q;
	pixbase_e sel_q; // select currently loaded into the PLL
	logic [RECONFIG_CNT_W-1:0] timeout_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			state_q <= RC_IDLE;
			sel_q <= PIXBASE_36; // PLL powers up in the 36 MHz setting
			timeout_q <= '0;
			rc_write_rom_o <= 1'b0;
			rc_start_o <= 1'b0;
			rc_reset_o <= 1'b0;
			vid_clk_ena_o <= 1'b0;
		end else begin
			rc_write_rom_o <= 1'b0;
			rc_start_o <= 1'b0;
			rc_reset_o <= 1'b0;
			case (state_q)
				RC_IDLE: begin
					vid_clk_ena_o <= 1'b1;
					sel_q <= pixbase_sel_i;
					if (sel_q != pixbase_sel_i) begin
						vid_clk_ena_o <= 1'b0; // hold video off during reload
						rc_write_rom_o <= 1'b1;
						state_q <= RC_LOAD;
					end
				end
				RC_LOAD: state_q <= RC_WAIT_IDLE;
				RC_WAIT_IDLE: begin
					if (!reconfig_busy_i) begin
						rc_start_o <= 1'b1;
						timeout_q <= RECONFIG_CNT_W'(RECONFIG_TIMEOUT);
						state_q <= RC_RUN;
					end
				end
				RC_RUN: begin
					timeout_q <= timeout_q - 1'b1;
					if (timeout_q == RECONFIG_CNT_W'(1)) begin
						// controller stuck busy, kick it
						rc_reset_o <= 1'b1;
						state_q <= RC_IDLE;
					end
					if (!rc_start_o && !reconfig_busy_i) begin
						state_q <= RC_IDLE;
					end
				end
				default: state_q <= RC_IDLE;
			endcase
		end
	end

	a_start_not_busy: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		rc_start_o |-> !reconfig_busy_i
	);

	// controller strobes are single cycle
	a_single_pulses: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		(rc_write_rom_o || rc_start_o || rc_reset_o) |=>
			!(rc_write_rom_o || rc_start_o || rc_reset_o)
	);

endmodule

/* source/clk_enable_gen.sv */
module clk_enable_gen import archie_clk_pkg::*; (
	input  logic clk_sys,
	input  logic rst_n_i,
	output logic clk2m_en_o,
	output logic clk8m_en_o
);

	logic [CLKEN_CNT_W-1:0] cnt_q; // wraps every CLKEN_PERIOD clocks

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
			clk2m_en_o <= 1'b0;
			clk8m_en_o <= 1'b0;
		end else begin
			if (cnt_q == CLKEN_CNT_W'(CLKEN_PERIOD - 1)) begin
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
			// decodes registered, so both pulses line up
			clk2m_en_o <= (cnt_q == '0);
			clk8m_en_o <= ((cnt_q % CLKEN_CNT_W'(CLK8M_STEP)) == '0);
		end
	end

	// 2 MHz edges must also be 8 MHz edges
	a_clk2m_in_clk8m: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		clk2m_en_o |-> clk8m_en_o
	);

endmodule

/* source/archie_mem_pkg.sv */
package archie_mem_pkg;

	// wishbone data path towards RAM
	localparam int MEM_DATA_W = 32;
	localparam int MEM_SEL_W = 4;

	// RAM side is byte addressed, 64 MB window
	localparam int RAM_ADDR_W = 26;

	// host download port
	localparam int LOADER_ADDR_W = 24;
	localparam int LOADER_INDEX_W = 8;

	// file indices that carry a ROM image
	localparam int ROM_INDEX_LO = 1;
	localparam int ROM_INDEX_HI = 2;

endpackage

/* source/archie_clk_pkg.sv */
package archie_clk_pkg;

	// enable generator, clk_sys divided by 20 and by 5
	localparam int CLKEN_PERIOD = 20;
	localparam int CLK8M_STEP = 5;
	localparam int CLKEN_CNT_W = $clog2(CLKEN_PERIOD);

	// cycles a busy reconfig controller gets before it is reset
	localparam int RECONFIG_TIMEOUT = 1000;
	localparam int RECONFIG_CNT_W = $clog2(RECONFIG_TIMEOUT + 1);

	// back porch blanking lengths in clocks
	localparam int PORCH_TV_LEN = 256;
	localparam int PORCH_VGA_LEN = 64;

	localparam int COLOR_W = 4; // bits per channel

	// pixel base clock select, equal bits mean TV timing
	typedef enum logic [1:0] {
		PIXBASE_24A = 2'b00,
		PIXBASE_25 = 2'b01,
		PIXBASE_36 = 2'b10,
		PIXBASE_24B = 2'b11
	} pixbase_e;

	typedef enum logic [1:0] {
		RC_IDLE,
		RC_LOAD,
		RC_WAIT_IDLE,
		RC_RUN
	} reconfig_state_e;

endpackage
